// ==== logic/pfe_pkg.sv ====
`default_nettype none

package pfe_pkg;

  // host side and dram side widths
  localparam int MSG_W      = 32;
  localparam int APP_DATA_W = 128;  // one dram beat
  localparam int ADDR_W     = 27;

  // pixel tagging
  localparam int PIX_W     = 20;   // top 20 bits of a pixel word, low bits dropped
  localparam int N_ROW_MAX = 2064; // 2k rows plus dark rows top and bottom
  localparam int N_COL_MAX = 2048;
  localparam int ROW_W     = $clog2(N_ROW_MAX);
  localparam int COL_W     = $clog2(N_COL_MAX + 1); // room to see the column run past the max
  localparam int FRAME_W   = 20;

  // coefficient grouping, 8 x 32 bits fill two 128 bit beats
  localparam int WORDS_PER_GROUP = 2 * APP_DATA_W / MSG_W;
  localparam int GRP_CNT_W       = $clog2(WORDS_PER_GROUP);
  localparam logic [ADDR_W-1:0] START_ADDR = '0;
  localparam logic [ADDR_W-1:0] ADDR_INC   = ADDR_W'(8); // one BL8 burst

  // message kind, low two bits of every host word
  localparam logic [1:0] KIND_PIXEL    = 2'd0;
  localparam logic [1:0] KIND_COEF_END = 2'd1; // closes the coefficient stream

  typedef enum logic [1:0] {STANDBY, INTERFRAME, INTRALINE, INTERLINE} trk_state_e;

  typedef enum logic [2:0] {COLLECT, WR_WAIT, WR1, WR2, DONE, ERROR} wr_state_e;

  // the same host word read as a pixel sample or as a coefficient
  typedef union packed {
    struct packed {
      logic [PIX_W-1:0] pix_data;
      logic [5:0]       rsvd_hi;
      logic             fval;     // frame valid
      logic             lval;     // line valid
      logic [1:0]       rsvd_lo;
      logic [1:0]       kind;
    } pix;
    struct packed {
      logic [MSG_W-3:0] payload;
      logic [1:0]       kind;
    } coef;
  } msg_word_u;

endpackage

`default_nettype wire

// ==== logic/msg_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_router import pfe_pkg::*; (
  input  wire logic      bus_clk,
  input  wire logic      fds_val,
  input  wire logic      pc_msg_empty,
  input  wire msg_word_u pc_msg,
  input  wire logic      coef_busy,
  output logic           pc_msg_ack,
  output logic           pix_stb,
  output msg_word_u      pix_word,
  output logic           coef_stb,
  output msg_word_u      coef_word
);

  logic [GRP_CNT_W-1:0] grp_cnt; // words taken so far in the current coef group
  logic                 is_pix;
  logic                 take_pix;
  logic                 take_coef;

  // fwft queue, so the ack itself is the pop
  assign pc_msg_ack = !pc_msg_empty && !coef_busy;

  // a group in progress swallows the next words whatever their kind
  assign is_pix    = (pc_msg.pix.kind == KIND_PIXEL) && (grp_cnt == '0);
  assign take_pix  = pc_msg_ack && is_pix;
  assign take_coef = pc_msg_ack && !is_pix;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      grp_cnt  <= '0;
      pix_stb  <= 1'b0;
      coef_stb <= 1'b0;
    end else begin
      pix_stb  <= take_pix;   // one strobe per popped word
      coef_stb <= take_coef;
      if (take_coef) begin
        grp_cnt <= grp_cnt + 1'b1; // wraps after the eighth word
      end
    end
  end

  // payload lines, only meaningful with their strobe
  always_ff @(posedge bus_clk) begin
    if (take_pix) begin
      pix_word <= pc_msg;
    end
    if (take_coef) begin
      coef_word <= pc_msg;
    end
  end

  // an unknown kind on a popped word would throw the group count off
  a_kind_known: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    pc_msg_ack |-> !$isunknown(pc_msg.pix.kind)
  ) else $error("msg_router: popped word with unknown kind");

endmodule

`default_nettype wire

// ==== logic/frame_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_tracker import pfe_pkg::*; (
  input  wire logic       bus_clk,
  input  wire logic       fds_val,
  input  wire logic       pix_stb,
  input  wire msg_word_u  pix_word,
  output logic            pix_valid,
  output logic [PIX_W-1:0]   pix_data,
  output logic [ROW_W-1:0]   pix_row,
  output logic [COL_W-1:0]   pix_col,
  output logic [FRAME_W-1:0] pix_frame
);

  trk_state_e         trk_state;
  logic [FRAME_W-1:0] frame_cnt;
  logic [ROW_W-1:0]   row_cnt;
  logic [COL_W-1:0]   col_cnt;   // column of the next pixel in the line

  logic             fval;
  logic             lval;
  logic             emit;      // this word carries a valid pixel
  logic [ROW_W-1:0] emit_row;
  logic [COL_W-1:0] emit_col;

  assign fval = pix_word.pix.fval;
  assign lval = pix_word.pix.lval;

  // any lval-high word outside standby is a pixel
  assign emit = pix_stb && lval && (trk_state != STANDBY);

  // first pixel of a frame sits at row 0, first of a line at column 0
  assign emit_row = (trk_state == INTERFRAME) ? '0 : row_cnt;
  assign emit_col = (trk_state == INTRALINE) ? col_cnt : '0;

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      trk_state <= STANDBY;
      frame_cnt <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= emit;
      if (pix_stb) begin
        case (trk_state)
          STANDBY: begin
            // wait for a gap between frames before tracking anything
            if (!fval) begin
              frame_cnt <= '0;
              trk_state <= INTERFRAME;
            end
          end
          INTERFRAME: begin
            if (lval) begin
              row_cnt   <= '0;
              col_cnt   <= COL_W'(1);
              trk_state <= INTRALINE;
            end
          end
          INTRALINE: begin
            if (lval) begin
              col_cnt <= col_cnt + 1'b1;
            end else if (fval) begin
              // line over, frame still open
              row_cnt   <= row_cnt + 1'b1;
              trk_state <= INTERLINE;
            end else begin
              frame_cnt <= frame_cnt + 1'b1; // last line closed the frame
              trk_state <= INTERFRAME;
            end
          end
          INTERLINE: begin
            if (lval) begin
              col_cnt   <= COL_W'(1);
              trk_state <= INTRALINE;
            end
          end
          default: begin
            trk_state <= STANDBY;
          end
        endcase
      end
    end
  end

  // tagged pixel, held until the next one
  always_ff @(posedge bus_clk) begin
    if (emit) begin
      pix_data  <= pix_word.pix.pix_data;
      pix_row   <= emit_row;
      pix_col   <= emit_col;
      pix_frame <= frame_cnt;
    end
  end

  // line longer than the sensor means fval/lval were lost upstream
  a_col_range: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    pix_valid |-> (pix_col < COL_W'(N_COL_MAX))
  ) else $error("frame_tracker: column %0d out of range", pix_col);

endmodule

`default_nettype wire

// ==== logic/coef_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_writer import pfe_pkg::*; (
  input  wire logic       bus_clk,
  input  wire logic       fds_val,
  input  wire logic       coef_stb,
  input  wire msg_word_u  coef_word,
  input  wire logic       app_rdy,
  input  wire logic       app_wdf_rdy,
  output logic            coef_busy,
  output logic            app_en,
  output logic [ADDR_W-1:0]     app_addr,
  output logic            app_wdf_wren,
  output logic            app_wdf_end,
  output logic [APP_DATA_W-1:0] app_wdf_data,
  output logic            coef_done,
  output logic            error
);

  wr_state_e              wr_state;
  logic [GRP_CNT_W-1:0]   wr_off;     // word slot, wraps on its own after 8
  logic [2*APP_DATA_W-1:0] grp_data;  // word 0 in the lsbs
  logic [1:0]             last_kind;  // kind of the word that closed the group

  logic collecting;
  logic grp_last;
  logic in_burst;

  assign collecting = (wr_state == COLLECT);
  assign grp_last   = collecting && coef_stb &&
                      (wr_off == GRP_CNT_W'(WORDS_PER_GROUP - 1));
  assign in_burst   = (wr_state == WR_WAIT) || (wr_state == WR1) || (wr_state == WR2);

  // also high while the eighth word lands, so the router stops popping
  // before the burst state is even entered
  assign coef_busy = in_burst || grp_last;

  assign coef_done = (wr_state == DONE);
  assign error     = (wr_state == ERROR); // sticky, only reset leaves it

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_state     <= COLLECT;
      wr_off       <= '0;
      app_en       <= 1'b0;
      app_addr     <= START_ADDR;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
    end else begin
      case (wr_state)
        COLLECT: begin
          if (coef_stb) begin
            wr_off <= wr_off + 1'b1;
            if (grp_last) begin
              app_en   <= 1'b1;  // request the write command
              wr_state <= WR_WAIT;
            end
          end
        end
        WR_WAIT: begin
          // command and write fifo must both be ready
          if (app_rdy && app_wdf_rdy) begin
            app_en       <= 1'b0;
            app_addr     <= app_addr + ADDR_INC; // next group's slot
            app_wdf_wren <= 1'b1;
            app_wdf_end  <= 1'b0;
            wr_state     <= WR1;
          end
        end
        WR1: begin
          // beat one held until the write fifo takes it
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;
            wr_state    <= WR2;
          end
        end
        WR2: begin
          app_wdf_wren <= 1'b0;
          app_wdf_end  <= 1'b0;
          if (!app_wdf_rdy) begin
            wr_state <= ERROR;  // beat two lost
          end else if (last_kind == KIND_COEF_END) begin
            wr_state <= DONE;
          end else begin
            wr_state <= COLLECT;
          end
        end
        DONE, ERROR: begin
          // later coefficient words are dropped here
        end
        default: begin
          wr_state <= ERROR;
        end
      endcase
    end
  end

  // group register and beat data
  always_ff @(posedge bus_clk) begin
    if (collecting && coef_stb) begin
      grp_data[wr_off*MSG_W +: MSG_W] <= coef_word;
      last_kind <= coef_word.coef.kind;
    end
    if (wr_state == WR_WAIT && app_rdy && app_wdf_rdy) begin
      app_wdf_data <= grp_data[0 +: APP_DATA_W];           // words 0 to 3
    end else if (wr_state == WR1 && app_wdf_rdy) begin
      app_wdf_data <= grp_data[APP_DATA_W +: APP_DATA_W];  // words 4 to 7
    end
  end

  // busy must hold the router off one cycle ahead of any new strobe
  a_no_stb_when_busy: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    coef_busy |=> !coef_stb
  ) else $error("coef_writer: coefficient word arrived during a burst");

  // burst steps on the dram ready levels, an x there would wedge the fsm
  a_rdy_known: assert property (
    @(posedge bus_clk) disable iff (fds_val)
    in_burst |-> !$isunknown({app_rdy, app_wdf_rdy})
  ) else $error("coef_writer: dram ready level unknown during a burst");

endmodule

`default_nettype wire

// ==== logic/patch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module patch_front_end import pfe_pkg::*; (
  input  wire logic       bus_clk,
  input  wire logic       fds_val,
  // host message queue, fwft
  input  wire logic       pc_msg_empty,
  input  wire msg_word_u  pc_msg,
  output logic            pc_msg_ack,
  // dram write port
  input  wire logic       app_rdy,
  input  wire logic       app_wdf_rdy,
  output logic            app_en,
  output logic [ADDR_W-1:0]     app_addr,
  output logic            app_wdf_wren,
  output logic            app_wdf_end,
  output logic [APP_DATA_W-1:0] app_wdf_data,
  // tagged pixels
  output logic            pix_valid,
  output logic [PIX_W-1:0]   pix_data,
  output logic [ROW_W-1:0]   pix_row,
  output logic [COL_W-1:0]   pix_col,
  output logic [FRAME_W-1:0] pix_frame,
  // status
  output logic            coef_done,
  output logic            error
);

  logic      pix_stb;
  msg_word_u pix_word;
  logic      coef_stb;
  msg_word_u coef_word;
  logic      coef_busy;  // writer back-pressure on the pop

  msg_router u_msg_router (
    .bus_clk, .fds_val, .pc_msg_empty, .pc_msg, .coef_busy,
    .pc_msg_ack, .pix_stb, .pix_word, .coef_stb, .coef_word
  );

  frame_tracker u_frame_tracker (
    .bus_clk, .fds_val, .pix_stb, .pix_word,
    .pix_valid, .pix_data, .pix_row, .pix_col, .pix_frame
  );

  coef_writer u_coef_writer (
    .bus_clk, .fds_val, .coef_stb, .coef_word, .app_rdy, .app_wdf_rdy,
    .coef_busy, .app_en, .app_addr, .app_wdf_wren, .app_wdf_end,
    .app_wdf_data, .coef_done, .error
  );

endmodule

`default_nettype wire

// ==== verif/tb_patch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_patch_front_end import pfe_pkg::*; ();

  localparam int TAG_W = PIX_W + ROW_W + COL_W + FRAME_W; // {data, row, col, frame}

  logic                  bus_clk;
  logic                  fds_val;
  logic                  pc_msg_empty;
  msg_word_u             pc_msg;
  logic                  pc_msg_ack;
  logic                  app_rdy;
  logic                  app_wdf_rdy;
  logic                  app_en;
  logic [ADDR_W-1:0]     app_addr;
  logic                  app_wdf_wren;
  logic                  app_wdf_end;
  logic [APP_DATA_W-1:0] app_wdf_data;
  logic                  pix_valid;
  logic [PIX_W-1:0]      pix_data;
  logic [ROW_W-1:0]      pix_row;
  logic [COL_W-1:0]      pix_col;
  logic [FRAME_W-1:0]    pix_frame;
  logic                  coef_done;
  logic                  error;

  msg_word_u             host_q[$];     // host fifo model, front word is on pc_msg
  logic [TAG_W-1:0]      exp_pix_q[$];
  logic [ADDR_W-1:0]     exp_addr_q[$];
  logic [APP_DATA_W:0]   exp_beat_q[$]; // {app_wdf_end, data}
  logic [TAG_W-1:0]      exp_tag;
  logic [APP_DATA_W:0]   exp_beat;
  int                    gap_pct;       // chance of an empty queue cycle
  int                    stall_pct;     // chance of a dram ready drop
  bit                    hold_rdy;      // app_rdy forced low
  bit                    err_mode;      // drop app_wdf_rdy under beat two
  int                    fail_cnt;
  int                    fail_base;
  int                    tests_ok;
  int                    tests_bad;
  int                    words_sent;
  int                    pix_seen;
  int                    pix_expected;
  int                    cycles;

  // reference model state
  trk_state_e              r_trk;
  int unsigned             r_frame;
  int unsigned             r_row;
  int unsigned             r_col;
  int unsigned             r_cnt;   // router view, words into the current group
  int unsigned             r_slot;  // writer view, stops once the writer is parked
  logic [2*APP_DATA_W-1:0] r_grp;
  logic [ADDR_W-1:0]       r_addr;
  bit                      r_stop;
  bit                      r_err_next;

  patch_front_end dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // host queue and dram ready model, falling edge
  always @(negedge bus_clk) begin
    pc_msg_empty = (fds_val !== 1'b0) || (host_q.size() == 0) || (($urandom % 100) < gap_pct);
    pc_msg       = (host_q.size() != 0) ? host_q[0] : '0;
    app_rdy      = !hold_rdy && (($urandom % 100) >= stall_pct);
    if (app_wdf_end === 1'b1)
      app_wdf_rdy = !err_mode; // burst-ending cycle
    else
      app_wdf_rdy = ($urandom % 100) >= stall_pct;
  end

  always @(posedge bus_clk) begin
    if (pc_msg_ack === 1'b1) host_q.delete(0); // fwft pop
  end

  function automatic void expect_eq(input string sig, input logic [APP_DATA_W:0] exp_v,
                                    input logic [APP_DATA_W:0] got_v);
    assert (got_v === exp_v) else begin
      $display("FAILED at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
      fail_cnt++;
    end
  endfunction

  function automatic void report_fault(input string what);
    $display("ERROR at %0t: %s", $time, what);
    fail_cnt++;
  endfunction

  // tracker rules, bit TAG_W flags that the word makes a pixel
  function automatic logic [TAG_W:0] ref_track(input msg_word_u w);
    logic hit;
    hit = 1'b0;
    case (r_trk)
      STANDBY: if (!w.pix.fval) begin
        r_frame = 0;
        r_trk   = INTERFRAME;
      end
      INTERFRAME: if (w.pix.lval) begin
        r_row = 0;
        r_col = 0;
        r_trk = INTRALINE;
        hit   = 1'b1;
      end
      INTRALINE: if (w.pix.lval) begin
        r_col++;
        hit = 1'b1;
      end else if (w.pix.fval) begin
        r_row++;                 // line gap
        r_trk = INTERLINE;
      end else begin
        r_frame++;               // frame gap
        r_trk = INTERFRAME;
      end
      default: if (w.pix.lval) begin // interline
        r_col = 0;
        r_trk = INTRALINE;
        hit   = 1'b1;
      end
    endcase
    return {hit, w.pix.pix_data, ROW_W'(r_row), COL_W'(r_col), FRAME_W'(r_frame)};
  endfunction

  // expected command and beats, queued once a group is complete
  function automatic void ref_coef(input msg_word_u w);
    if (!r_stop) begin
      r_grp[r_slot*MSG_W +: MSG_W] = w;
      r_slot = (r_slot + 1) % WORDS_PER_GROUP;
      if (r_slot == 0) begin
        exp_addr_q.push_back(r_addr);
        r_addr = r_addr + ADDR_INC;
        exp_beat_q.push_back({1'b0, r_grp[APP_DATA_W-1:0]});
        if (!r_err_next)
          exp_beat_q.push_back({1'b1, r_grp[2*APP_DATA_W-1:APP_DATA_W]}); // lost on error
        r_stop = r_err_next || (w.coef.kind == KIND_COEF_END);
      end
    end
  endfunction

  task automatic send_word(input msg_word_u w);
    logic [TAG_W:0] res;
    if (w.pix.kind == KIND_PIXEL && r_cnt == 0) begin
      res = ref_track(w);
      if (res[TAG_W]) begin
        exp_pix_q.push_back(res[TAG_W-1:0]);
        pix_expected++;
      end
    end else begin
      r_cnt = (r_cnt + 1) % WORDS_PER_GROUP; // any kind counts once a group is open
      ref_coef(w);
    end
    host_q.push_back(w);
    words_sent++;
  endtask

  task automatic send_line(input int len, input bit last);
    msg_word_u w;
    for (int i = 0; i < len; i++) begin
      w = '0;
      w.pix.pix_data = PIX_W'($urandom);
      w.pix.fval     = 1'b1;
      w.pix.lval     = 1'b1;
      send_word(w);
    end
    w = '0;
    w.pix.fval = !last; // closing word, ends the frame after the last line
    send_word(w);
  endtask

  task automatic send_group(input logic [1:0] first_kind, mid_kind, last_kind);
    msg_word_u w;
    for (int i = 0; i < WORDS_PER_GROUP; i++) begin
      w.coef.payload = (MSG_W-2)'($urandom);
      w.coef.kind    = (i == 0) ? first_kind :
                       (i == WORDS_PER_GROUP - 1) ? last_kind : mid_kind;
      send_word(w);
    end
  endtask

  task automatic apply_reset();
    fds_val = 1'b1;
    {hold_rdy, err_mode, r_stop, r_err_next} = '0;
    {r_frame, r_row, r_col, r_cnt, r_slot} = '0;
    r_trk  = STANDBY;
    r_addr = START_ADDR;
    repeat (16) @(posedge bus_clk);
    @(negedge bus_clk);
    fds_val = 1'b0;
  endtask

  task automatic wait_idle();
    while (host_q.size() != 0 || exp_pix_q.size() != 0 ||
           exp_addr_q.size() != 0 || exp_beat_q.size() != 0)
      @(negedge bus_clk);
    repeat (30) @(negedge bus_clk); // room for stray pixels or commands
  endtask

  task automatic end_test(input int num, input string name);
    if (fail_cnt == fail_base) begin
      $display("test %0d %s: ok", num, name);
      tests_ok++;
    end else begin
      $display("test %0d %s: %0d check(s) failed", num, name, fail_cnt - fail_base);
      tests_bad++;
    end
    fail_base = fail_cnt;
  endtask

  // compare, sampled at the rising edge where outputs are settled
  always @(posedge bus_clk) begin
    if (fds_val === 1'b0) begin
      if (pix_valid) begin
        pix_seen++;
        assert (exp_pix_q.size() != 0) else report_fault("pix_valid with no pixel expected");
        if (exp_pix_q.size() != 0) begin
          exp_tag = exp_pix_q.pop_front();
          expect_eq("pix_data", exp_tag[TAG_W-1 -: PIX_W], pix_data);
          expect_eq("pix_row", exp_tag[ROW_W+COL_W+FRAME_W-1 -: ROW_W], pix_row);
          expect_eq("pix_col", exp_tag[COL_W+FRAME_W-1 -: COL_W], pix_col);
          expect_eq("pix_frame", exp_tag[FRAME_W-1:0], pix_frame);
        end
      end
      if (app_en || app_wdf_wren) expect_eq("pc_msg_ack", 0, pc_msg_ack); // burst pending
      assert (!app_en || exp_addr_q.size() != 0) else report_fault("app_en with no group due");
      if (app_en && app_rdy && app_wdf_rdy && exp_addr_q.size() != 0)
        expect_eq("app_addr", exp_addr_q.pop_front(), app_addr);
      if (app_wdf_wren && app_wdf_rdy) begin
        assert (exp_beat_q.size() != 0) else report_fault("write beat with no beat expected");
        if (exp_beat_q.size() != 0) begin
          exp_beat = exp_beat_q.pop_front();
          expect_eq("app_wdf_data", exp_beat[APP_DATA_W-1:0], app_wdf_data);
          expect_eq("app_wdf_end", exp_beat[APP_DATA_W], app_wdf_end);
        end
      end
    end
  end

  // watchdog, budget grows with every word sent
  initial begin
    cycles = 0;
    while (cycles <= words_sent * 20 + 2000) begin
      @(posedge bus_clk);
      cycles++;
    end
    $display("timeout: run stalled after %0d cycles", cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    fds_val      = 1'b1;
    pc_msg_empty = 1'b1;
    pc_msg       = '0;
    app_rdy      = 1'b0;
    app_wdf_rdy  = 1'b0;
    void'($urandom(12024));
    apply_reset();

    @(negedge bus_clk);
    expect_eq("pc_msg_ack", 0, pc_msg_ack);
    expect_eq("pix_valid", 0, pix_valid);
    expect_eq("app_en", 0, app_en);
    expect_eq("app_wdf_wren", 0, app_wdf_wren);
    expect_eq("app_wdf_end", 0, app_wdf_end);
    expect_eq("coef_done", 0, coef_done);
    expect_eq("error", 0, error);
    expect_eq("coef_busy", 0, dut.coef_busy);
    expect_eq("app_addr", START_ADDR, app_addr);
    end_test(1, "reset state");

    gap_pct = 30;
    send_word('0);  // leaves standby
    send_line(5, 0);
    send_line(9, 0);
    send_line(3, 1);
    send_word('0);
    send_line(7, 0);
    send_line(2, 0);
    send_line(11, 1);
    wait_idle();
    expect_eq("pixel count", pix_expected, pix_seen);
    end_test(2, "frame tracking");

    stall_pct = 40;
    send_group(2'd2, 2'd3, 2'd2);
    send_group(2'd3, 2'd2, 2'd3);
    send_group(2'd2, 2'd2, 2'd0);
    wait_idle();
    end_test(3, "coefficient bursts");

    stall_pct = 0;
    hold_rdy  = 1'b1;
    send_group(2'd2, 2'd2, 2'd3);
    send_line(6, 1);
    while (app_en !== 1'b1) @(negedge bus_clk);
    repeat (50) @(negedge bus_clk);
    assert (host_q.size() != 0) else report_fault("pixel words popped while app_rdy was low");
    hold_rdy = 1'b0;
    wait_idle();
    expect_eq("pixel count", pix_expected, pix_seen);
    end_test(4, "back-pressure");

    stall_pct = 30;
    send_group(2'd2, KIND_PIXEL, KIND_PIXEL);
    send_line(4, 1);
    send_group(2'd3, 2'd2, KIND_COEF_END);
    send_group(2'd2, 2'd2, 2'd2); // writer parked, no command expected
    send_group(2'd3, 2'd3, 2'd3);
    send_line(3, 1);
    wait_idle();
    expect_eq("coef_done", 1, coef_done);
    expect_eq("pixel count", pix_expected, pix_seen);
    end_test(5, "classification and end marker");

    apply_reset();
    stall_pct  = 20;
    err_mode   = 1'b1;
    r_err_next = 1'b1;
    send_group(2'd2, 2'd3, 2'd2);
    send_group(2'd3, 2'd2, 2'd2);
    wait_idle();
    expect_eq("error", 1, error);
    repeat (20) @(negedge bus_clk);
    expect_eq("error", 1, error);
    expect_eq("coef_done", 0, coef_done);
    end_test(6, "write error");

    $display("%0d tests ok, %0d tests failed, %0d failed checks", tests_ok, tests_bad, fail_cnt);
    if (fail_cnt == 0 && tests_bad == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/pfe_pkg.sv
logic/msg_router.sv
logic/frame_tracker.sv
logic/coef_writer.sv
logic/patch_front_end.sv
verif/tb_patch_front_end.sv

// ==== Bender.yml ====
package:
  name: patch_front_end

sources:
  - logic/pfe_pkg.sv
  - logic/msg_router.sv
  - logic/frame_tracker.sv
  - logic/coef_writer.sv
  - logic/patch_front_end.sv
  - target: test
    files:
      - verif/tb_patch_front_end.sv
